// File: files.f
+incdir+src
+incdir+test
src/mipsPkg.sv
src/mipsAlu.sv
src/mipsRegisters.sv
src/mipsControl.sv
src/mipsDatapath.sv
src/mipsCore.sv
test/tbMipsCore.sv

// File: src/mipsAlu.sv
//**********************************************************************
// Integer ALU
//   mode and funct decode
//   add, sub, and, or, signed set-less-than, zero flag
//**********************************************************************
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsAlu (
	input  logic [`MIPS_WORD_W-1:0] a,
	input  logic [`MIPS_WORD_W-1:0] b,
	input  mipsPkg::aluModeT        aluMode,
	input  mipsPkg::functT          funct,
	output logic [`MIPS_WORD_W-1:0] result,
	output logic                    zero
);

	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);	// Two's complement compare

	always_comb
	begin
		case (aluMode)
			mipsPkg::modeAdd: result = a + b;	// Addresses, PC step, addi
			mipsPkg::modeSub: result = a - b;	// Branch compare
			mipsPkg::modeFunct:
				case (funct)
					mipsPkg::fnAdd: result = a + b;
					mipsPkg::fnSub: result = a - b;
					mipsPkg::fnAnd: result = a & b;
					mipsPkg::fnOr:  result = a | b;
					mipsPkg::fnSlt: result = {{(`MIPS_WORD_W-1){1'b0}}, lessThan};
					default:        result = '0;	// Unsupported funct
				endcase
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: src/mipsControl.sv
//**********************************************************************
// Multicycle control FSM
//   fetch, decode, execute, memory and writeback sequencing
//   memory request hold until ready, capture enable gating
//   halt detection
//**********************************************************************
`timescale 1ns/1ps

module mipsControl (
	input  logic             iCLK,
	input  logic             iRST,
	input  mipsPkg::opcodeT  opcode,
	input  logic             memReady,
	output logic             memValid,
	output logic             memWrite,
	output logic             irWrite,
	output logic             mdrWrite,
	output logic             pcWrite,
	output logic             pcWriteEq,
	output logic             pcWriteNe,
	output logic [1:0]       pcSource,
	output logic             aluSrcA,
	output logic [1:0]       aluSrcB,
	output mipsPkg::aluModeT aluMode,
	output logic             regWrite,
	output logic             regDst,
	output logic             memToReg,
	output logic             iorD,
	output logic             halted
);

	mipsPkg::stateT state, nextState;
	logic ack;	// Transfer on this edge

	assign ack = memValid && memReady;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state    <= mipsPkg::sFetch;
			memValid <= 1'b0;
			memWrite <= 1'b0;
		end
		else
		begin
			state    <= nextState;
			// Request held across stalls, dropped after the transfer
			memValid <= (nextState == mipsPkg::sFetch) || (nextState == mipsPkg::sMemRead)
				|| (nextState == mipsPkg::sMemWrite);
			memWrite <= (nextState == mipsPkg::sMemWrite);
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			mipsPkg::sFetch:    if (ack) nextState = mipsPkg::sDecode;
			mipsPkg::sDecode:
				case (opcode)
					mipsPkg::opR:    nextState = mipsPkg::sExecR;
					mipsPkg::opAddi: nextState = mipsPkg::sExecImm;
					mipsPkg::opLw,
					mipsPkg::opSw:   nextState = mipsPkg::sAddrCalc;
					mipsPkg::opBeq,
					mipsPkg::opBne:  nextState = mipsPkg::sBranch;
					mipsPkg::opJ:    nextState = mipsPkg::sJump;
					default:         nextState = mipsPkg::sHalt;	// Halt and unknown opcodes
				endcase
			mipsPkg::sExecR:    nextState = mipsPkg::sWbR;
			mipsPkg::sExecImm:  nextState = mipsPkg::sWbImm;
			mipsPkg::sAddrCalc: nextState = (opcode == mipsPkg::opLw) ? mipsPkg::sMemRead
				: mipsPkg::sMemWrite;
			mipsPkg::sMemRead:  if (ack) nextState = mipsPkg::sWbLoad;
			mipsPkg::sMemWrite: if (ack) nextState = mipsPkg::sFetch;
			mipsPkg::sHalt:     nextState = mipsPkg::sHalt;	// Until reset
			default:            nextState = mipsPkg::sFetch;	// Writebacks, branch, jump
		endcase
	end

	// ALUOut reloads every cycle, so waiting states repeat their ALU setup
	always_comb
	begin
		irWrite = 1'b0; mdrWrite = 1'b0; pcWrite = 1'b0;
		pcWriteEq = 1'b0; pcWriteNe = 1'b0; pcSource = 2'd0;
		aluSrcA = 1'b1; aluSrcB = 2'd2; aluMode = mipsPkg::modeAdd;	// A plus immediate
		regWrite = 1'b0; regDst = 1'b0; memToReg = 1'b0; iorD = 1'b0;
		case (state)
			mipsPkg::sFetch:
			begin
				aluSrcA = 1'b0; aluSrcB = 2'd1;	// PC plus step
				irWrite = ack;
				pcWrite = ack;
			end
			mipsPkg::sDecode:
			begin
				aluSrcA = 1'b0; aluSrcB = 2'd3;	// Branch target into ALUOut
			end
			mipsPkg::sExecR, mipsPkg::sWbR:
			begin
				aluSrcB = 2'd0; aluMode = mipsPkg::modeFunct;
				regWrite = (state == mipsPkg::sWbR);
				regDst = 1'b1;	// rd
			end
			mipsPkg::sWbImm: regWrite = 1'b1;
			mipsPkg::sMemRead:
			begin
				iorD = 1'b1;
				mdrWrite = ack;
			end
			mipsPkg::sMemWrite: iorD = 1'b1;
			mipsPkg::sWbLoad:
			begin
				regWrite = 1'b1;
				memToReg = 1'b1;
			end
			mipsPkg::sBranch:
			begin
				aluSrcB = 2'd0; aluMode = mipsPkg::modeSub;	// Zero on equal
				pcSource = 2'd1;
				pcWriteEq = (opcode == mipsPkg::opBeq);
				pcWriteNe = (opcode == mipsPkg::opBne);
			end
			mipsPkg::sJump:
			begin
				pcSource = 2'd2;
				pcWrite = 1'b1;
			end
			default: ;	// ExecImm, AddrCalc and Halt keep the defaults
		endcase
	end

	assign halted = (state == mipsPkg::sHalt);

endmodule

// File: src/mipsCore.sv
//**********************************************************************
// Multicycle MIPS core top level
//   control FSM and datapath joined by the control bus
//   single valid/ready memory request port
//**********************************************************************
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsCore (
	input  logic                    iCLK,
	input  logic                    iRST,
	output logic                    memValid,
	input  logic                    memReady,
	output logic                    memWrite,
	output logic [`MIPS_WORD_W-1:0] memAddr,
	output logic [`MIPS_WORD_W-1:0] memWdata,
	input  logic [`MIPS_WORD_W-1:0] memRdata,
	output logic                    halted
);

	mipsPkg::opcodeT opcode;	// Decoded from IR
	mipsPkg::aluModeT aluMode;
	logic irWrite, mdrWrite, pcWrite, pcWriteEq, pcWriteNe;
	logic aluSrcA, regWrite, regDst, memToReg, iorD;
	logic [1:0] pcSource, aluSrcB;

	mipsControl control (
		.iCLK(iCLK), .iRST(iRST),
		.opcode(opcode),
		.memReady(memReady),
		.memValid(memValid), .memWrite(memWrite),
		.irWrite(irWrite), .mdrWrite(mdrWrite),
		.pcWrite(pcWrite), .pcWriteEq(pcWriteEq), .pcWriteNe(pcWriteNe),
		.pcSource(pcSource),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluMode(aluMode),
		.regWrite(regWrite), .regDst(regDst), .memToReg(memToReg), .iorD(iorD),
		.halted(halted)
	);

	// Address and store data come from the datapath
	mipsDatapath datapath (
		.iCLK(iCLK), .iRST(iRST),
		.irWrite(irWrite), .mdrWrite(mdrWrite),
		.pcWrite(pcWrite), .pcWriteEq(pcWriteEq), .pcWriteNe(pcWriteNe),
		.pcSource(pcSource),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluMode(aluMode),
		.regWrite(regWrite), .regDst(regDst), .memToReg(memToReg), .iorD(iorD),
		.opcode(opcode),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memRdata(memRdata)
	);

endmodule

// File: src/mipsDatapath.sv
//**********************************************************************
// Multicycle datapath
//   PC, IR, A, B, MDR and ALUOut registers
//   field decode, ALU operand and next PC selection
//   branch decision, register bank and ALU instances
//**********************************************************************
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsDatapath (
	input  logic                    iCLK,
	input  logic                    iRST,
	input  logic                    irWrite,
	input  logic                    mdrWrite,
	input  logic                    pcWrite,
	input  logic                    pcWriteEq,
	input  logic                    pcWriteNe,
	input  logic [1:0]              pcSource,
	input  logic                    aluSrcA,
	input  logic [1:0]              aluSrcB,
	input  mipsPkg::aluModeT        aluMode,
	input  logic                    regWrite,
	input  logic                    regDst,
	input  logic                    memToReg,
	input  logic                    iorD,
	output mipsPkg::opcodeT         opcode,
	output logic [`MIPS_WORD_W-1:0] memAddr,
	output logic [`MIPS_WORD_W-1:0] memWdata,
	input  logic [`MIPS_WORD_W-1:0] memRdata
);

	logic [`MIPS_WORD_W-1:0] pc, ir, a, b, mdr, aluOut;
	logic [`MIPS_WORD_W-1:0] readData1, readData2, aluA, aluB, aluResult, nextPc;
	logic [`MIPS_WORD_W-1:0] immediate, branchOffset, jumpTarget, writeData;
	logic [`MIPS_REG_ADDR_W-1:0] rs, rt, rd, writeReg;
	mipsPkg::functT funct;
	logic aluZero, pcLoad;
	logic decodeCycle;	// IR holds a freshly fetched instruction

	// Instruction fields
	assign opcode = mipsPkg::opcodeT'(ir[31:26]);
	assign funct  = mipsPkg::functT'(ir[5:0]);
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign immediate    = {{(`MIPS_WORD_W-16){ir[15]}}, ir[15:0]};
	assign branchOffset = {immediate[`MIPS_WORD_W-3:0], 2'b00};	// Word offset
	assign jumpTarget   = {pc[`MIPS_WORD_W-1:28], ir[25:0], 2'b00};

	assign aluA = aluSrcA ? a : pc;
	always_comb
	begin
		case (aluSrcB)
			2'd0:    aluB = b;
			2'd1:    aluB = `MIPS_PC_STEP;
			2'd2:    aluB = immediate;
			default: aluB = branchOffset;
		endcase
	end

	always_comb
	begin
		case (pcSource)
			2'd1:    nextPc = aluOut;	// Branch target from decode
			2'd2:    nextPc = jumpTarget;
			default: nextPc = aluResult;	// Incremented PC
		endcase
	end

	assign writeReg  = regDst ? rd : rt;
	assign writeData = memToReg ? mdr : aluOut;
	assign memAddr   = iorD ? aluOut : pc;
	assign memWdata  = b;
	assign pcLoad = pcWrite || (pcWriteEq && aluZero) || (pcWriteNe && !aluZero);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pc <= `MIPS_RESET_PC;
			decodeCycle <= 1'b0;
		end
		else
		begin
			decodeCycle <= irWrite;	// Cycle after an accepted fetch
			if (pcLoad)
				pc <= nextPc;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (irWrite) ir <= memRdata;	// Only on an accepted fetch
		if (mdrWrite) mdr <= memRdata;
		if (decodeCycle)
		begin
			a <= readData1;	// Operands held until next decode
			b <= readData2;
		end
		aluOut <= aluResult;
	end

	mipsRegisters registers (
		.iCLK(iCLK), .iRST(iRST),
		.readReg1(rs), .readReg2(rt), .writeReg(writeReg),
		.writeData(writeData), .regWrite(regWrite),
		.readData1(readData1), .readData2(readData2)
	);

	mipsAlu alu (
		.a(aluA), .b(aluB),
		.aluMode(aluMode), .funct(funct),
		.result(aluResult), .zero(aluZero)
	);

endmodule

// File: src/mipsPkg.sv
//**********************************************************************
// Shared types of the multicycle MIPS core
//   opcode and funct encodings, ALU request mode
//   control FSM state encoding
//**********************************************************************
package mipsPkg;

	typedef enum logic [5:0] {
		opR    = 6'h00,	// Register format, funct selects op
		opJ    = 6'h02,
		opBeq  = 6'h04,
		opBne  = 6'h05,
		opAddi = 6'h08,
		opLw   = 6'h23,
		opSw   = 6'h2B,
		opHalt = 6'h3F	// Reserved opcode, stops the core
	} opcodeT;

	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2A	// Signed compare
	} functT;

	// What control asks of the ALU
	typedef enum logic [1:0] {
		modeAdd   = 2'd0,
		modeSub   = 2'd1,
		modeFunct = 2'd2	// Defer to funct field
	} aluModeT;

	typedef enum logic [3:0] {
		sFetch, sDecode, sExecR, sExecImm, sAddrCalc, sMemRead, sMemWrite,
		sWbR, sWbImm, sWbLoad, sBranch, sJump, sHalt
	} stateT;

endpackage

// File: src/mipsRegisters.sv
//**********************************************************************
// General purpose register bank
//   two combinational read ports, one write port
//   register 0 hardwired to zero
//**********************************************************************
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsRegisters (
	input  logic                        iCLK,
	input  logic                        iRST,
	input  logic [`MIPS_REG_ADDR_W-1:0] readReg1,
	input  logic [`MIPS_REG_ADDR_W-1:0] readReg2,
	input  logic [`MIPS_REG_ADDR_W-1:0] writeReg,
	input  logic [`MIPS_WORD_W-1:0]     writeData,
	input  logic                        regWrite,
	output logic [`MIPS_WORD_W-1:0]     readData1,
	output logic [`MIPS_WORD_W-1:0]     readData2
);

	logic [`MIPS_WORD_W-1:0] regs [`MIPS_NUM_REGS];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			for (int i = 0; i < `MIPS_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (regWrite && (writeReg != '0))	// Register 0 never written
			regs[writeReg] <= writeData;
	end

	assign readData1 = (readReg1 == '0) ? '0 : regs[readReg1];
	assign readData2 = (readReg2 == '0) ? '0 : regs[readReg2];

endmodule

// File: src/mips_cfg.svh
//**********************************************************************
// Configuration macros for the multicycle MIPS core
//   word and register index widths, register count
//   program counter value after reset and its increment
//**********************************************************************
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Data and address width
`define MIPS_WORD_W 32

// Register bank geometry
`define MIPS_REG_ADDR_W 5
`define MIPS_NUM_REGS 32

// First fetch address
`define MIPS_RESET_PC 32'h0000_0000

// Sequential PC advance, one word
`define MIPS_PC_STEP 32'd4

`endif

// File: test/tbMipsRef.svh
//**********************************************************************
// Testbench helpers for the multicycle MIPS core
//   xorshift generator, instruction encoders, program image
//   instruction-set reference model, value check
//**********************************************************************
`ifndef TB_MIPS_REF_SVH
`define TB_MIPS_REF_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s ^ (s << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [31:0] rFormat(input logic [5:0] fn, input logic [4:0] rs,
	input logic [4:0] rt, input logic [4:0] rd);
	return {6'h00, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] jFormat(input logic [25:0] target);
	return {6'h02, target};	// Word index of target
endfunction

task automatic loadProgram();
	for (int i = 0; i < MEM_WORDS; i++)
	begin
		rngState = xorshift(rngState);
		mem[i] = rngState;	// Random data everywhere, program overlays it
	end
	mem[0]  = iFormat(6'h08, 0, 1, 16'h0200);	// r1 = data base
	mem[1]  = iFormat(6'h23, 1, 2, 16'h0000);
	mem[2]  = iFormat(6'h23, 1, 3, 16'h0004);
	mem[3]  = rFormat(6'h20, 2, 3, 4);
	mem[4]  = rFormat(6'h22, 2, 3, 5);
	mem[5]  = rFormat(6'h24, 2, 3, 6);
	mem[6]  = rFormat(6'h25, 2, 3, 7);
	mem[7]  = rFormat(6'h2A, 2, 3, 8);	// Signed compare of random words
	mem[8]  = iFormat(6'h08, 0, 9, 16'hFFFB);	// r9 = -5
	mem[9]  = rFormat(6'h2A, 9, 0, 10);	// -5 < 0
	mem[10] = rFormat(6'h2A, 0, 9, 11);
	mem[11] = iFormat(6'h08, 0, 0, 16'h0007);	// Lost write to r0
	mem[12] = rFormat(6'h20, 2, 3, 0);
	mem[13] = iFormat(6'h2B, 1, 4, 16'h0080);
	mem[14] = iFormat(6'h2B, 1, 5, 16'h0084);
	mem[15] = iFormat(6'h2B, 1, 6, 16'h0088);
	mem[16] = iFormat(6'h2B, 1, 7, 16'h008C);
	mem[17] = iFormat(6'h2B, 1, 8, 16'h0090);
	mem[18] = iFormat(6'h2B, 1, 10, 16'h0094);
	mem[19] = iFormat(6'h2B, 1, 11, 16'h0098);
	mem[20] = iFormat(6'h2B, 1, 0, 16'h009C);	// r0 must still be zero
	mem[21] = iFormat(6'h08, 0, 12, 16'h0003);	// Loop count
	mem[22] = iFormat(6'h08, 1, 13, 16'h0008);	// Source pointer
	mem[23] = iFormat(6'h23, 13, 14, 16'h0000);	// Loop top
	mem[24] = iFormat(6'h2B, 13, 14, 16'h00A0);
	mem[25] = iFormat(6'h08, 13, 13, 16'h0004);
	mem[26] = iFormat(6'h08, 12, 12, 16'hFFFF);
	mem[27] = iFormat(6'h05, 12, 0, 16'hFFFB);	// bne back to 23
	mem[28] = iFormat(6'h04, 12, 0, 16'h0001);	// Taken beq skips 29
	mem[29] = iFormat(6'h2B, 1, 0, 16'h0000);
	mem[30] = iFormat(6'h04, 1, 0, 16'h0001);	// Untaken beq
	mem[31] = iFormat(6'h2B, 1, 1, 16'h00C0);
	mem[32] = jFormat(26'd34);	// Skips 33
	mem[33] = iFormat(6'h2B, 1, 0, 16'h0004);
	mem[34] = iFormat(6'h05, 12, 0, 16'h0001);	// Untaken bne
	mem[35] = iFormat(6'h2B, 1, 9, 16'h00C4);
	mem[36] = iFormat(6'h23, 1, 15, 16'h0080);	// Reload an earlier store
	mem[37] = iFormat(6'h2B, 1, 15, 16'h00C8);
	mem[38] = {6'h3F, 26'd0};	// Halt
endtask

// Runs the image at instruction level, fills the expected store list
function automatic int referenceRun();
	logic [31:0] refMem [MEM_WORDS];
	logic [31:0] regs [32];
	logic [31:0] pc, inst, srcA, srcB, imm, result, addr;
	int steps;
	logic done;
	refMem = mem;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	pc = `MIPS_RESET_PC;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 500)
	begin
		inst = refMem[pc[9:2]];
		pc = pc + `MIPS_PC_STEP;
		srcA = regs[inst[25:21]];
		srcB = regs[inst[20:16]];
		imm = {{16{inst[15]}}, inst[15:0]};
		addr = srcA + imm;
		case (inst[31:26])
			6'h00:
			begin
				case (inst[5:0])
					6'h20: result = srcA + srcB;
					6'h22: result = srcA - srcB;
					6'h24: result = srcA & srcB;
					6'h25: result = srcA | srcB;
					6'h2A: result = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
					default: result = '0;	// Unknown funct
				endcase
				if (inst[15:11] != 5'd0)
					regs[inst[15:11]] = result;
			end
			6'h08: if (inst[20:16] != 5'd0) regs[inst[20:16]] = addr;	// addi
			6'h23: if (inst[20:16] != 5'd0) regs[inst[20:16]] = refMem[addr[9:2]];
			6'h2B:
			begin
				refMem[addr[9:2]] = srcB;
				expAddr.push_back(addr);
				expData.push_back(srcB);
			end
			6'h04: if (srcA == srcB) pc = pc + {imm[29:0], 2'b00};
			6'h05: if (srcA != srcB) pc = pc + {imm[29:0], 2'b00};
			6'h02: pc = {pc[31:28], inst[25:0], 2'b00};
			default: done = 1'b1;	// Halt or unknown opcode
		endcase
		steps++;
	end
	return expAddr.size();
endfunction

task automatic check(input logic [31:0] actual, input logic [31:0] expected,
	input string what);
	if (actual !== expected)
		abortRun($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
			$time, what, actual, expected));
endtask

`endif

// File: test/tbMipsCore.sv
//**********************************************************************
// Testbench of the multicycle MIPS core
//   clock, reset, memory model with random ready
//   stall stability checks, store compare, timeout, final status
//**********************************************************************
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tbMipsCore;

	localparam int MEM_WORDS = 256;	// 1 KB, program at 0, data from 0x200
	localparam int MAX_CYCLES = 3000;	// About 60 instructions, worst case stalls

	logic iCLK, iRST;
	logic memValid, memReady, memWrite, halted;
	logic [`MIPS_WORD_W-1:0] memAddr, memWdata, memRdata;

	logic [31:0] mem [MEM_WORDS];
	logic [31:0] expAddr [$];	// Reference store stream
	logic [31:0] expData [$];
	logic [31:0] gotAddr [$];	// Accepted stores, not yet compared
	logic [31:0] gotData [$];
	logic [31:0] rngState, heldAddr, heldWdata;
	logic heldWrite, waiting;
	int expCount, storeCount, cycles, requests;

	`include "tbMipsRef.svh"

	mipsCore dut (
		.iCLK(iCLK), .iRST(iRST),
		.memValid(memValid), .memReady(memReady), .memWrite(memWrite),
		.memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata),
		.halted(halted)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #50 iCLK = ~iCLK;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	// Memory model, runs on the falling edge
	task automatic serviceMemory();
		if (waiting)
		begin
			check(32'(memValid), 1, "memValid held during stall");
			check(32'(memWrite), 32'(heldWrite), "memWrite held during stall");
			check(memAddr, heldAddr, "memAddr held during stall");
			check(memWdata, heldWdata, "memWdata held during stall");
		end
		if (memValid && memAddr[31:10] != '0)
			abortRun("The core requested an address outside the modeled memory");
		rngState = xorshift(rngState);
		memReady = (rngState[31:30] != 2'b00);	// Ready three cycles in four
		memRdata = mem[memAddr[9:2]];	// Valid in the accepting cycle
		if (memValid && memReady)
		begin
			if (requests == 0)
			begin
				check(32'(memWrite), 0, "first request direction");
				check(memAddr, `MIPS_RESET_PC, "first request address");
			end
			requests++;
			if (memWrite)
			begin
				mem[memAddr[9:2]] = memWdata;
				gotAddr.push_back(memAddr);
				gotData.push_back(memWdata);
			end
		end
		waiting = memValid && !memReady;
		heldWrite = memWrite;
		heldAddr = memAddr;
		heldWdata = memWdata;
	endtask

	// Store comparator
	always @(posedge iCLK)
	begin
		while (gotAddr.size() > 0)
		begin
			if (expAddr.size() == 0)
				abortRun("The core stored more words than the reference program");
			else
			begin
				check(gotAddr.pop_front(), expAddr.pop_front(), "store address");
				check(gotData.pop_front(), expData.pop_front(), "store data");
				storeCount++;
			end
		end
	end

	initial
	begin
		iRST = 1'b1;
		memReady = 1'b0;
		memRdata = '0;
		rngState = 32'hca20_fbd4;
		waiting = 1'b0;
		heldWrite = 1'b0;
		heldAddr = '0;
		heldWdata = '0;
		requests = 0;
		storeCount = 0;
		cycles = 0;
		loadProgram();
		expCount = referenceRun();
		repeat (2)
		begin
			@(negedge iCLK);
			check(32'(memValid), 0, "memValid during reset");
			check(32'(halted), 0, "halted during reset");
		end
		iRST = 1'b0;
		while (!halted)
		begin
			@(negedge iCLK);
			cycles++;
			if (cycles > MAX_CYCLES)
				abortRun($sformatf("Timeout after %0d cycles, the core never halted",
					MAX_CYCLES));
			else
				serviceMemory();
		end
		repeat (4)	// Core must stay quiet in halt
		begin
			@(negedge iCLK);
			if (memValid || !halted)
				abortRun("The core made a request or left halt after the halt instruction");
		end
		if (storeCount == expCount)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
			check(storeCount, expCount, "store count at halt");
	end

endmodule
